// File: hw/adder_subtractor.sv
/* alu adder/subtractor
   byte and pair add/subtract variants, carry out means no borrow on subtract */
`timescale 1ns/10ps

module adder_subtractor
(
	input  alu_pkg::addsub_oper_t             oper,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]    a_hi,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]    a_lo,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]    b_lo,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]    b_hi,
	input  logic                              carry_in,
	output logic [alu_pkg::BYTE_WIDTH-1:0]    sum_hi,
	output logic [alu_pkg::BYTE_WIDTH-1:0]    sum_lo,
	output logic                              carry_out
);

	import alu_pkg::*;

	// 16-bit views of the operands
	logic [PAIR_WIDTH-1:0] a_pair;
	logic [PAIR_WIDTH-1:0] b_full;
	logic [PAIR_WIDTH-1:0] b_zext;
	logic [PAIR_WIDTH-1:0] b_sext;

	// sums with one extra bit for carry
	logic [BYTE_WIDTH:0]   byte_sum;
	logic [PAIR_WIDTH:0]   pair_sum;

	assign a_pair = {a_hi, a_lo};
	assign b_full = {b_hi, b_lo};
	assign b_zext = {{BYTE_WIDTH{1'b0}}, b_lo};
	// sign extension of the immediate byte
	assign b_sext = {{BYTE_WIDTH{b_lo[BYTE_WIDTH-1]}}, b_lo};

	always_comb
	begin
		byte_sum = '0;
		pair_sum = '0;
		case (oper)
			addsub_add:
			begin
				byte_sum = {1'b0, a_lo} + {1'b0, b_lo};
			end
			addsub_adc:
			begin
				byte_sum = {1'b0, a_lo} + {1'b0, b_lo}
					+ {{BYTE_WIDTH{1'b0}}, carry_in};
			end
			// a + ~b + 1
			addsub_sub:
			begin
				byte_sum = {1'b0, a_lo} + {1'b0, ~b_lo}
					+ {{BYTE_WIDTH{1'b0}}, 1'b1};
			end
			// carry in as "no borrow"
			addsub_sbc:
			begin
				byte_sum = {1'b0, a_lo} + {1'b0, ~b_lo}
					+ {{BYTE_WIDTH{1'b0}}, carry_in};
			end
			addsub_addpb:
			begin
				pair_sum = {1'b0, a_pair} + {1'b0, b_zext};
			end
			addsub_addp:
			begin
				pair_sum = {1'b0, a_pair} + {1'b0, b_full};
			end
			addsub_addpsnx:
			begin
				pair_sum = {1'b0, a_pair} + {1'b0, b_sext};
			end
			addsub_subpb:
			begin
				pair_sum = {1'b0, a_pair} + {1'b0, ~b_zext}
					+ {{PAIR_WIDTH{1'b0}}, 1'b1};
			end
			addsub_subp:
			begin
				pair_sum = {1'b0, a_pair} + {1'b0, ~b_full}
					+ {{PAIR_WIDTH{1'b0}}, 1'b1};
			end
			default:
			begin
				byte_sum = '0;
				pair_sum = '0;
			end
		endcase
	end

	// route byte or pair sum to the outputs
	always_comb
	begin
		case (oper)
			addsub_add, addsub_adc, addsub_sub, addsub_sbc:
			begin
				sum_hi = '0;
				{carry_out, sum_lo} = byte_sum;
			end
			addsub_addpb, addsub_addp, addsub_subpb, addsub_subp:
			begin
				{carry_out, sum_hi, sum_lo} = pair_sum;
			end
			// sign extended add never reports carry
			addsub_addpsnx:
			begin
				{sum_hi, sum_lo} = pair_sum[PAIR_WIDTH-1:0];
				carry_out = 1'b0;
			end
			default:
			begin
				{carry_out, sum_hi, sum_lo} = '0;
			end
		endcase
	end

endmodule

// File: hw/alu_core.sv
/* alu core
   opcode decode, bitwise ops, unit result select and zero flag */
`timescale 1ns/10ps

module alu_core
(
	input  alu_pkg::alu_oper_t              oper,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  a_hi,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  a_lo,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  b_hi,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  b_lo,
	input  logic [alu_pkg::FLAGS_WIDTH-1:0] flags_in,
	output logic [alu_pkg::BYTE_WIDTH-1:0]  res_hi,
	output logic [alu_pkg::BYTE_WIDTH-1:0]  res_lo,
	output logic [alu_pkg::FLAGS_WIDTH-1:0] flags_out
);

	import alu_pkg::*;

	// which unit the result comes from
	typedef enum logic [2:0]
	{
		sel_addsub, sel_logic, sel_byte_sh, sel_pair_sh, sel_hold
	} res_sel_t;

	res_sel_t              res_sel;
	res_sel_t              out_sel;
	addsub_oper_t          addsub_op;
	shift_oper_t           sh_kind;
	shift_oper_t           byte_sh_op;
	shift_oper_t           pair_sh_op;
	logic                  uses_count;
	logic                  hold;
	logic [BYTE_WIDTH-1:0] logic_hi;
	logic [BYTE_WIDTH-1:0] logic_lo;

	// unit outputs
	logic [BYTE_WIDTH-1:0] sum_hi;
	logic [BYTE_WIDTH-1:0] sum_lo;
	logic                  addsub_carry;
	logic [BYTE_WIDTH-1:0] byte_sh_res;
	logic                  byte_sh_carry;
	logic [PAIR_WIDTH-1:0] pair_sh_res;
	logic                  pair_sh_carry;

	logic                  carry_next;
	logic                  zero_next;

	adder_subtractor addsub
	(
		.oper      (addsub_op),
		.a_hi      (a_hi),
		.a_lo      (a_lo),
		.b_lo      (b_lo),
		.b_hi      (b_hi),
		.carry_in  (flags_in[FLAG_C]),
		.sum_hi    (sum_hi),
		.sum_lo    (sum_lo),
		.carry_out (addsub_carry)
	);

	shift_rotate #(.WIDTH(BYTE_WIDTH)) byte_shifter
	(
		.oper      (byte_sh_op),
		.value     (a_lo),
		.count     (b_lo),
		.carry_in  (flags_in[FLAG_C]),
		.result    (byte_sh_res),
		.carry_out (byte_sh_carry)
	);

	shift_rotate #(.WIDTH(PAIR_WIDTH)) pair_shifter
	(
		.oper      (pair_sh_op),
		.value     ({a_hi, a_lo}),
		.count     (b_lo),
		.carry_in  (flags_in[FLAG_C]),
		.result    (pair_sh_res),
		.carry_out (pair_sh_carry)
	);

	// result source per opcode
	always_comb
	begin
		case (oper)
			op_add, op_adc, op_addpb, op_addp, op_addpsnx,
			op_sub, op_sbc, op_subpb, op_subp:
				res_sel = sel_addsub;
			op_and, op_orr, op_xor, op_inv, op_neg, op_invp, op_negp:
				res_sel = sel_logic;
			op_lsl, op_lsr, op_asr, op_rol, op_ror, op_rolc, op_rorc:
				res_sel = sel_byte_sh;
			op_lslp, op_lsrp, op_asrp, op_rolp, op_rorp, op_rolcp, op_rorcp:
				res_sel = sel_pair_sh;
			// nop and undefined code hold
			default:
				res_sel = sel_hold;
		endcase
	end

	// adder code
	always_comb
	begin
		case (oper)
			op_add:     addsub_op = addsub_add;
			op_adc:     addsub_op = addsub_adc;
			op_addpb:   addsub_op = addsub_addpb;
			op_addp:    addsub_op = addsub_addp;
			op_addpsnx: addsub_op = addsub_addpsnx;
			op_sub:     addsub_op = addsub_sub;
			op_sbc:     addsub_op = addsub_sbc;
			op_subpb:   addsub_op = addsub_subpb;
			op_subp:    addsub_op = addsub_subp;
			default:    addsub_op = addsub_none;
		endcase
	end

	// shift kind shared by byte and pair forms
	always_comb
	begin
		case (oper)
			op_lsl, op_lslp:   sh_kind = sh_lsl;
			op_lsr, op_lsrp:   sh_kind = sh_lsr;
			op_asr, op_asrp:   sh_kind = sh_asr;
			op_rol, op_rolp:   sh_kind = sh_rol;
			op_ror, op_rorp:   sh_kind = sh_ror;
			op_rolc, op_rolcp: sh_kind = sh_rolc;
			op_rorc, op_rorcp: sh_kind = sh_rorc;
			default:           sh_kind = sh_none;
		endcase
	end

	assign byte_sh_op = (res_sel == sel_byte_sh) ? sh_kind : sh_none;
	assign pair_sh_op = (res_sel == sel_pair_sh) ? sh_kind : sh_none;

	// count in b_lo, single bit through carry ignores it
	assign uses_count = (sh_kind != sh_none) && (sh_kind != sh_rolc)
		&& (sh_kind != sh_rorc);

	// bitwise results
	always_comb
	begin
		// byte forms leave the high half zero
		logic_hi = '0;
		case (oper)
			op_and:  logic_lo = a_lo & b_lo;
			op_orr:  logic_lo = a_lo | b_lo;
			op_xor:  logic_lo = a_lo ^ b_lo;
			op_inv:  logic_lo = ~a_lo;
			op_neg:  logic_lo = -a_lo;
			op_invp: {logic_hi, logic_lo} = ~{a_hi, a_lo};
			op_negp: {logic_hi, logic_lo} = -{a_hi, a_lo};
			default: logic_lo = '0;
		endcase
	end

	// zero count or nop passes a and flags untouched
	assign hold = (res_sel == sel_hold) || (uses_count && (b_lo == '0));
	assign out_sel = hold ? sel_hold : res_sel;

	always_comb
	begin
		case (out_sel)
			sel_addsub:
			begin
				{res_hi, res_lo} = {sum_hi, sum_lo};
				carry_next = addsub_carry;
			end
			// bitwise ops keep carry
			sel_logic:
			begin
				{res_hi, res_lo} = {logic_hi, logic_lo};
				carry_next = flags_in[FLAG_C];
			end
			sel_byte_sh:
			begin
				{res_hi, res_lo} = {{BYTE_WIDTH{1'b0}}, byte_sh_res};
				carry_next = byte_sh_carry;
			end
			sel_pair_sh:
			begin
				{res_hi, res_lo} = pair_sh_res;
				carry_next = pair_sh_carry;
			end
			default:
			begin
				{res_hi, res_lo} = {a_hi, a_lo};
				carry_next = flags_in[FLAG_C];
			end
		endcase
	end

	// zero over low byte or full pair
	always_comb
	begin
		if (hold)
			zero_next = flags_in[FLAG_Z];
		else if (is_byte_op(oper))
			zero_next = (res_lo == '0);
		else
			zero_next = ({res_hi, res_lo} == '0);
	end

	always_comb
	begin
		flags_out = '0;
		flags_out[FLAG_C] = carry_next;
		flags_out[FLAG_Z] = zero_next;
	end

endmodule

// File: hw/alu_pkg.sv
/* small cpu alu shared definitions
   operand widths, flag slots, opcode encodings and the byte/pair zero rule */
package alu_pkg;

	// one operand half and a hi:lo register pair
	parameter int BYTE_WIDTH  = 8;
	parameter int PAIR_WIDTH  = 16;

	// processor flags word
	parameter int FLAGS_WIDTH = 2;
	parameter int FLAG_C      = 0;
	parameter int FLAG_Z      = 1;

	// top level opcodes with code 31 left undefined
	typedef enum logic [4:0]
	{
		op_add, op_adc, op_addpb, op_addp, op_addpsnx,
		op_sub, op_sbc, op_subpb, op_subp,
		op_and, op_orr, op_xor,
		op_inv, op_invp, op_neg, op_negp,
		op_lsl, op_lsr, op_asr,
		op_rol, op_ror, op_rolc, op_rorc,
		op_lslp, op_lsrp, op_asrp,
		op_rolp, op_rorp, op_rolcp, op_rorcp,
		op_nop
	} alu_oper_t;

	// adder/subtractor operation codes
	typedef enum logic [3:0]
	{
		addsub_add, addsub_adc, addsub_addpb, addsub_addp, addsub_addpsnx,
		addsub_sub, addsub_sbc, addsub_subpb, addsub_subp,
		addsub_none
	} addsub_oper_t;

	// width independent shift and rotate kinds
	typedef enum logic [2:0]
	{
		sh_lsl, sh_lsr, sh_asr,
		sh_rol, sh_ror,
		sh_rolc, sh_rorc,
		sh_none
	} shift_oper_t;

	// zero flag over low byte only?
	function automatic logic is_byte_op(alu_oper_t op);
		logic byte_op;
		case (op)
			op_add, op_adc, op_sub, op_sbc,
			op_and, op_orr, op_xor, op_inv, op_neg,
			op_lsl, op_lsr, op_asr,
			op_rol, op_ror, op_rolc, op_rorc:
			begin
				byte_op = 1'b1;
			end
			// pair forms, nop and undefined
			default:
			begin
				byte_op = 1'b0;
			end
		endcase
		return byte_op;
	endfunction

endpackage

// File: hw/alu_unit.sv
/* registered alu top level
   runs one operation per exec strobe, holds result and flags, pulses done */
`timescale 1ns/10ps

module alu_unit
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            exec,
	input  alu_pkg::alu_oper_t              oper,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  a_hi,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  a_lo,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  b_hi,
	input  logic [alu_pkg::BYTE_WIDTH-1:0]  b_lo,
	input  logic                            flags_wr,
	input  logic [alu_pkg::FLAGS_WIDTH-1:0] flags_data,
	output logic [alu_pkg::BYTE_WIDTH-1:0]  out_hi,
	output logic [alu_pkg::BYTE_WIDTH-1:0]  out_lo,
	output logic [alu_pkg::FLAGS_WIDTH-1:0] flags,
	output logic                            done
);

	import alu_pkg::*;

	// combinational next state from the core
	logic [BYTE_WIDTH-1:0]  core_hi;
	logic [BYTE_WIDTH-1:0]  core_lo;
	logic [FLAGS_WIDTH-1:0] core_flags;

	// carry and zero fed back from the flags register
	alu_core core
	(
		.oper      (oper),
		.a_hi      (a_hi),
		.a_lo      (a_lo),
		.b_hi      (b_hi),
		.b_lo      (b_lo),
		.flags_in  (flags),
		.res_hi    (core_hi),
		.res_lo    (core_lo),
		.flags_out (core_flags)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			done <= 1'b0;
			out_hi <= '0;
			out_lo <= '0;
			flags <= '0;
		end
		else
		begin
			// one cycle after exec
			done <= exec;
			if (exec)
			begin
				out_hi <= core_hi;
				out_lo <= core_lo;
				flags <= core_flags;
			end
			// direct load loses to exec
			else if (flags_wr)
			begin
				flags <= flags_data;
			end
		end
	end

endmodule

// File: hw/shift_rotate.sv
/* width-parameterized shift and rotate unit
   shifts by count, rotates by count mod width, one-bit rotates through carry */
`timescale 1ns/10ps

module shift_rotate
#(
	parameter int WIDTH = 8
)
(
	input  alu_pkg::shift_oper_t           oper,
	input  logic [WIDTH-1:0]               value,
	input  logic [alu_pkg::BYTE_WIDTH-1:0] count,
	input  logic                           carry_in,
	output logic [WIDTH-1:0]               result,
	output logic                           carry_out
);

	import alu_pkg::*;

	// shift words carry one extra slot for the bit shifted out
	logic [WIDTH:0]         lsl_word;
	logic [WIDTH:0]         lsr_word;
	logic [WIDTH:0]         asr_word;
	// doubled value for rotates
	logic [2*WIDTH-1:0]     rol_word;
	logic [2*WIDTH-1:0]     ror_word;
	logic [BYTE_WIDTH-1:0]  rot_amt;
	logic                   count_over;

	// carry lands in the top slot
	assign lsl_word = {1'b0, value} << count;
	// carry lands in bit 0
	assign lsr_word = {value, 1'b0} >> count;
	assign asr_word = $signed({value, 1'b0}) >>> count;

	// past the width asr still shifts out sign bits
	assign count_over = (count > BYTE_WIDTH'(WIDTH));

	assign rot_amt  = count % BYTE_WIDTH'(WIDTH);
	assign rol_word = {value, value} << rot_amt;
	assign ror_word = {value, value} >> rot_amt;

	always_comb
	begin
		case (oper)
			sh_lsl:
			begin
				{carry_out, result} = lsl_word;
			end
			sh_lsr:
			begin
				{result, carry_out} = lsr_word;
			end
			sh_asr:
			begin
				result = asr_word[WIDTH:1];
				carry_out = count_over ? 1'b0 : asr_word[0];
			end
			// rotates by count leave carry alone
			sh_rol:
			begin
				result = rol_word[2*WIDTH-1:WIDTH];
				carry_out = carry_in;
			end
			sh_ror:
			begin
				result = ror_word[WIDTH-1:0];
				carry_out = carry_in;
			end
			// one bit rotate of {carry, value} as a WIDTH+1 word
			sh_rolc:
			begin
				{carry_out, result} = {value, carry_in};
			end
			sh_rorc:
			begin
				{result, carry_out} = {carry_in, value};
			end
			default:
			begin
				result = value;
				carry_out = carry_in;
			end
		endcase
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the alu testbench with verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
	--top-module tb_alu_unit \
	-f small_alu.f \
	--Mdir obj_dir \
	-o tb_alu_unit

./obj_dir/tb_alu_unit > sim.log
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// File: sim/alu_stimulus.txt
# load oper a_hi a_lo b_hi b_lo flags exp_hi exp_lo exp_flags, all hex
# load 0 issues back to back on the previous flags; flags bit 0 carry, bit 1 zero
1 00 12 3c 00 14 0 00 50 0
1 00 00 80 00 80 0 00 00 3
1 01 00 7f 00 01 1 00 81 0
1 05 00 50 00 20 0 00 30 1
1 05 00 20 00 50 0 00 d0 0
1 06 00 50 00 20 0 00 2f 1
1 02 12 f0 55 20 0 13 10 0
1 02 ff ff 00 01 0 00 00 3
1 04 10 00 00 ff 1 0f ff 0
1 04 10 00 00 7f 0 10 7f 0
1 07 13 00 ff 01 0 12 ff 1
1 08 00 01 00 02 0 ff ff 0
1 09 aa f0 00 3c 1 00 30 1
1 09 00 f0 00 0f 0 00 00 2
1 0b 77 a5 00 a5 1 00 00 3
1 0d 00 ff 00 00 1 ff 00 1
1 0e 00 01 00 00 2 00 ff 0
1 0f 01 00 00 00 1 ff 00 1
1 10 00 81 00 01 0 00 02 1
1 10 00 01 00 08 0 00 00 3
1 10 00 ff 00 09 1 00 00 2
1 11 00 81 00 01 0 00 40 1
1 11 12 34 00 00 3 12 34 3
1 12 00 80 00 02 1 00 e0 0
1 12 00 81 00 0a 1 00 ff 0
1 17 00 01 00 10 0 00 00 3
1 19 be ef 00 00 2 be ef 2
1 13 00 81 00 01 1 00 03 1
1 13 00 81 00 09 0 00 03 0
1 14 44 5a 00 00 1 44 5a 1
1 1b 00 01 00 11 1 80 00 1
1 15 00 80 00 00 1 00 01 1
1 16 00 01 00 00 1 00 80 1
1 1c 80 00 00 00 1 00 01 1
1 1d 00 01 00 00 0 00 00 3
1 1e 12 34 56 78 3 12 34 3
1 1f 00 a5 00 00 1 00 a5 1
1 01 00 ff 00 01 0 00 00 3
0 01 00 10 00 20 0 00 31 0
0 01 00 f0 00 10 0 00 00 3
0 06 00 05 00 05 0 00 00 3
0 1e 00 07 00 00 0 00 07 3

// File: sim/tb_alu_unit.sv
/* testbench for the registered alu
   file driven check of result and flags on every done pulse */
`timescale 1ns/10ps

module tb_alu_unit;

	import alu_pkg::*;

	localparam int MAX_TESTS = 128;

	logic                   clk;
	logic                   rst_n;
	logic                   exec;
	alu_oper_t              oper;
	logic [BYTE_WIDTH-1:0]  a_hi;
	logic [BYTE_WIDTH-1:0]  a_lo;
	logic [BYTE_WIDTH-1:0]  b_hi;
	logic [BYTE_WIDTH-1:0]  b_lo;
	logic                   flags_wr;
	logic [FLAGS_WIDTH-1:0] flags_data;
	logic [BYTE_WIDTH-1:0]  out_hi;
	logic [BYTE_WIDTH-1:0]  out_lo;
	logic [FLAGS_WIDTH-1:0] flags;
	logic                   done;

	// one entry per stimulus line
	logic       t_load    [MAX_TESTS];
	logic [4:0] t_oper    [MAX_TESTS];
	logic [7:0] t_a_hi    [MAX_TESTS];
	logic [7:0] t_a_lo    [MAX_TESTS];
	logic [7:0] t_b_hi    [MAX_TESTS];
	logic [7:0] t_b_lo    [MAX_TESTS];
	logic [7:0] t_flags   [MAX_TESTS];
	logic [7:0] t_exp_hi  [MAX_TESTS];
	logic [7:0] t_exp_lo  [MAX_TESTS];
	logic [7:0] t_exp_flg [MAX_TESTS];
	int         n_tests;
	logic       file_ok;

	// tests issued but not yet answered by done
	int   pending[$];
	logic exec_prev;
	int   checks;
	int   value_errors;
	int   protocol_errors;
	int   cycles;
	int   cycle_limit;

	alu_unit dut
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.exec       (exec),
		.oper       (oper),
		.a_hi       (a_hi),
		.a_lo       (a_lo),
		.b_hi       (b_hi),
		.b_lo       (b_lo),
		.flags_wr   (flags_wr),
		.flags_data (flags_data),
		.out_hi     (out_hi),
		.out_lo     (out_lo),
		.flags      (flags),
		.done       (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAILED time=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// reads hex columns and skips lines starting with #
	task automatic read_stimulus();
		int         fd;
		int         fields;
		string      line;
		logic [7:0] ld, op, ah, al, bh, bl, fl, eh, el, ef;
		n_tests = 0;
		file_ok = 1'b0;
		fd = $fopen("sim/alu_stimulus.txt", "r");
		if (fd != 0)
		begin
			file_ok = 1'b1;
			while (!$feof(fd) && n_tests < MAX_TESTS)
			begin
				if ($fgets(line, fd) == 0)
					break;
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
					ld, op, ah, al, bh, bl, fl, eh, el, ef);
				if (fields != 10)
					continue;
				t_load[n_tests] = ld[0];
				t_oper[n_tests] = op[4:0];
				t_a_hi[n_tests] = ah;
				t_a_lo[n_tests] = al;
				t_b_hi[n_tests] = bh;
				t_b_lo[n_tests] = bl;
				t_flags[n_tests] = fl;
				t_exp_hi[n_tests] = eh;
				t_exp_lo[n_tests] = el;
				t_exp_flg[n_tests] = ef;
				n_tests++;
			end
			$fclose(fd);
		end
	endtask

	// outputs sampled mid cycle away from the driving edge
	always @(negedge clk)
	begin : monitor
		int        idx;
		alu_oper_t op_name;
		if (rst_n)
		begin
			// done must mirror exec one cycle later
			if (done !== exec_prev)
			begin
				protocol_errors++;
				$display("done was %b at time %0t but exec one cycle before was %b",
					done, $time, exec_prev);
			end
			if (done === 1'b1)
			begin
				if (pending.size() == 0)
				begin
					protocol_errors++;
					$display("done pulse at time %0t with no operation pending", $time);
				end
				else
				begin
					idx = pending.pop_front();
					op_name = alu_oper_t'(t_oper[idx]);
					check_value($sformatf("out_hi (test %0d %s)", idx, op_name.name()),
						16'(out_hi), 16'(t_exp_hi[idx]));
					check_value($sformatf("out_lo (test %0d %s)", idx, op_name.name()),
						16'(out_lo), 16'(t_exp_lo[idx]));
					check_value($sformatf("flags (test %0d %s)", idx, op_name.name()),
						16'(flags), 16'(t_exp_flg[idx][FLAGS_WIDTH-1:0]));
				end
			end
		end
		exec_prev = exec;
	end

	// run limit from the number of tests
	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, %0d operations never answered by done",
				cycles, pending.size());
			$display(">>> FAIL");
			$finish;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		exec = 1'b0;
		oper = op_nop;
		a_hi = '0;
		a_lo = '0;
		b_hi = '0;
		b_lo = '0;
		flags_wr = 1'b0;
		flags_data = '0;
		exec_prev = 1'b0;
		checks = 0;
		value_errors = 0;
		protocol_errors = 0;
		cycles = 0;
		cycle_limit = 0;
		read_stimulus();
		if (!file_ok || n_tests == 0)
		begin
			$display("stimulus file sim/alu_stimulus.txt is missing or holds no tests");
			$display(">>> FAIL");
			$finish;
		end
		else
		begin
			cycle_limit = 3 * n_tests + 20;
			repeat (2) @(posedge clk);
			rst_n <= 1'b1;
			for (int i = 0; i < n_tests; i++)
			begin
				// chained lines run on the flags of the previous result
				if (t_load[i])
				begin
					@(posedge clk);
					exec <= 1'b0;
					flags_wr <= 1'b1;
					flags_data <= t_flags[i][FLAGS_WIDTH-1:0];
				end
				@(posedge clk);
				exec <= 1'b1;
				oper <= alu_oper_t'(t_oper[i]);
				a_hi <= t_a_hi[i];
				a_lo <= t_a_lo[i];
				b_hi <= t_b_hi[i];
				b_lo <= t_b_lo[i];
				// conflicting flags load alongside exec must lose
				flags_wr <= 1'b1;
				flags_data <= ~t_exp_flg[i][FLAGS_WIDTH-1:0];
				pending.push_back(i);
			end
			@(posedge clk);
			exec <= 1'b0;
			flags_wr <= 1'b0;
			while (pending.size() != 0)
				@(negedge clk);
			// catch any stray done after the last result
			repeat (2) @(negedge clk);
			$display("summary: %0d tests, %0d checks, %0d value errors, %0d protocol errors",
				n_tests, checks, value_errors, protocol_errors);
			if (value_errors == 0 && protocol_errors == 0)
			begin
				$display(">>> PASS");
			end
			else
			begin
				$display(">>> FAIL");
			end
			$finish;
		end
	end

endmodule

// File: small_alu.f
hw/alu_pkg.sv
hw/adder_subtractor.sv
hw/shift_rotate.sv
hw/alu_core.sv
hw/alu_unit.sv
sim/tb_alu_unit.sv
